// ==== project.f ====
hw/ao_periph_pkg.sv
hw/obi_to_reg.sv
hw/reg_demux.sv
hw/soc_ctrl.sv
hw/ao_timer.sv
hw/power_manager.sv
hw/pad_attribute.sv
hw/ao_peripheral_subsystem.sv
test/tb_ao_peripheral_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       := tb_ao_peripheral_subsystem
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Test OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_ao_peripheral_subsystem.sv ====
////////////////////
// Drives the OBI port on the falling edge, one request at a time
// Stops at the first mismatch or timeout
////////////////////
`default_nettype none

module tb_ao_peripheral_subsystem;

  import ao_periph_pkg::*;

  typedef enum logic [2:0] {
    STEP_WRITE,
    STEP_READ,
    STEP_TIMER_IRQ,
    STEP_SLEEP,
    STEP_WAKE
  } step_kind_e;

  // Timer steps carry the channel in addr and the compare value in data
  typedef struct packed {
    step_kind_e  kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] exp;
  } step_t;

  localparam int TIMEOUT = 64;

  logic                     clk;
  logic                     rst_n;
  obi_req_t                 slave_req;
  obi_resp_t                slave_resp;
  logic                     boot_select;
  logic                     execute_from_flash;
  logic                     exit_valid;
  logic [31:0]              exit_value;
  logic [NUM_GPIO_IRQ-1:0]  gpio_intr;
  logic [NUM_EXT_IRQ-1:0]   ext_intr;
  logic                     core_sleep;
  logic                     cpu_sw;
  logic                     periph_sw;
  logic [NUM_BANKS-1:0]     bank_sw;
  logic                     cpu_rst_n;
  logic                     periph_rst_n;
  logic [NUM_BANKS-1:0]     bank_rst_n;
  logic                     timer_0_intr;
  logic                     timer_1_intr;
  logic                     timer_2_intr;
  logic                     timer_3_intr;
  logic [NUM_PAD-1:0][15:0] pad_attr;

  step_t       steps[$];
  logic [31:0] rng_state;
  logic [31:0] exit_rand;
  logic [15:0] pad_exp[NUM_PAD];
  logic [31:0] rd;

  ao_peripheral_subsystem uut (
    .clk_i                                      (clk),
    .rst_n_i                                    (rst_n),
    .slave_req_i                                (slave_req),
    .slave_resp_o                               (slave_resp),
    .boot_select_i                              (boot_select),
    .execute_from_flash_i                       (execute_from_flash),
    .exit_valid_o                               (exit_valid),
    .exit_value_o                               (exit_value),
    .gpio_intr_i                                (gpio_intr),
    .ext_intr_i                                 (ext_intr),
    .core_sleep_i                               (core_sleep),
    .cpu_subsystem_powergate_switch_o           (cpu_sw),
    .peripheral_subsystem_powergate_switch_o    (periph_sw),
    .memory_subsystem_banks_powergate_switches_o(bank_sw),
    .cpu_subsystem_rst_no                       (cpu_rst_n),
    .peripheral_subsystem_rst_no                (periph_rst_n),
    .memory_subsystem_rst_no                    (bank_rst_n),
    .timer_0_intr_o                             (timer_0_intr),
    .timer_1_intr_o                             (timer_1_intr),
    .timer_2_intr_i                             (timer_2_intr),
    .timer_3_intr_i                             (timer_3_intr),
    .pad_attributes_o                           (pad_attr)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] reg_addr(input logic [3:0] idx, input logic [3:0] ofs);
    return {16'b0, idx, 6'b0, ofs, 2'b0};
  endfunction

  function automatic logic irq_level(input int ch);
    return (ch == 0) ? timer_0_intr : timer_1_intr;
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("Test FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic add_step(input step_kind_e kind, input logic [31:0] addr,
                          input logic [31:0] data, input logic [31:0] exp);
    step_t s;
    s.kind = kind;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    steps.push_back(s);
  endtask

  // Called on a falling edge, returns on the falling edge where rvalid is seen
  task automatic bus_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int cycles;
    slave_req.req   = 1'b1;
    slave_req.we    = we;
    slave_req.be    = 4'hf;
    slave_req.addr  = addr;
    slave_req.wdata = wdata;
    @(posedge clk);
    check("slave_resp_o.gnt", 32'(slave_resp.gnt), 32'd1);
    @(negedge clk);
    slave_req.req = 1'b0;
    slave_req.we  = 1'b0;
    cycles = 1;
    while (!slave_resp.rvalid && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (!slave_resp.rvalid) begin
      stop_run($sformatf("Timeout waiting for rvalid after access to %h", addr));
    end
    check("rvalid latency", 32'(cycles), 32'd1);
    rdata = slave_resp.rdata;
  endtask

  task automatic wait_irq(input int ch, input logic level, input int limit,
                          output int cycles);
    cycles = 0;
    while (irq_level(ch) !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (irq_level(ch) !== level) begin
      stop_run($sformatf("Timeout waiting for timer %0d interrupt to go %0b", ch, level));
    end
  endtask

  task automatic run_timer(input int ch, input logic [31:0] n);
    logic [31:0] r;
    int          cycles;
    bus_access(1'b1, reg_addr(TIMER_IDX, TMR_CMP0_OFS + 4'(ch)), n, r);
    bus_access(1'b1, reg_addr(TIMER_IDX, TMR_CTRL_OFS), 32'd1 << ch, r);
    wait_irq(ch, 1'b1, int'(n) + 4, cycles);
    if (cycles < int'(n)) begin
      stop_run($sformatf("Timer %0d interrupt after %0d cycles, compare is %0d",
                         ch, cycles, n));
    end
    bus_access(1'b1, reg_addr(TIMER_IDX, TMR_CNT0_OFS + 4'(ch)), 32'd0, r);
    wait_irq(ch, 1'b0, 3, cycles);
    bus_access(1'b1, reg_addr(TIMER_IDX, TMR_CTRL_OFS), 32'd0, r);
  endtask

  task automatic sleep_cpu();
    core_sleep = 1'b1;
    @(negedge clk);
    check("cpu_subsystem_rst_no", 32'(cpu_rst_n), 32'd0);
    check("cpu_subsystem_powergate_switch_o", 32'(cpu_sw), 32'd1);
    @(negedge clk);
    check("cpu_subsystem_powergate_switch_o", 32'(cpu_sw), 32'd0);
    core_sleep = 1'b0;
  endtask

  task automatic wake_cpu(input logic [NUM_GPIO_IRQ-1:0] gpio, input logic wakes);
    gpio_intr = gpio;
    if (wakes) begin
      @(negedge clk);
      check("cpu_subsystem_powergate_switch_o", 32'(cpu_sw), 32'd1);
      check("cpu_subsystem_rst_no", 32'(cpu_rst_n), 32'd0);
      @(negedge clk);
      check("cpu_subsystem_rst_no", 32'(cpu_rst_n), 32'd1);
      @(negedge clk);
    end else begin
      repeat (4) begin
        @(negedge clk);
        check("cpu_subsystem_powergate_switch_o", 32'(cpu_sw), 32'd0);
        check("cpu_subsystem_rst_no", 32'(cpu_rst_n), 32'd0);
      end
    end
    gpio_intr = '0;
  endtask

  task automatic bank_cycle(input int bank);
    logic [31:0]          r;
    logic [NUM_BANKS-1:0] on;
    on       = '1;
    on[bank] = 1'b0;
    bus_access(1'b1, reg_addr(POWER_MANAGER_IDX, PM_BANK_ON_OFS), 32'(on), r);
    check("memory_subsystem_rst_no", 32'(bank_rst_n[bank]), 32'd0);
    check("memory_subsystem_banks_powergate_switches_o", 32'(bank_sw[bank]), 32'd1);
    @(negedge clk);
    check("memory_subsystem_banks_powergate_switches_o", 32'(bank_sw[bank]), 32'd0);
    bus_access(1'b1, reg_addr(POWER_MANAGER_IDX, PM_BANK_ON_OFS), 32'({NUM_BANKS{1'b1}}), r);
    check("memory_subsystem_banks_powergate_switches_o", 32'(bank_sw[bank]), 32'd1);
    check("memory_subsystem_rst_no", 32'(bank_rst_n[bank]), 32'd0);
    @(negedge clk);
    check("memory_subsystem_rst_no", 32'(bank_rst_n[bank]), 32'd1);
  endtask

  task automatic build_table();
    logic [31:0] d;
    add_step(STEP_READ, reg_addr(SOC_CTRL_IDX, SOC_BOOT_SEL_OFS), 32'd0, 32'd1);
    add_step(STEP_READ, reg_addr(SOC_CTRL_IDX, SOC_FLASH_OFS), 32'd0, 32'd0);
    exit_rand = next_rand();
    add_step(STEP_WRITE, reg_addr(SOC_CTRL_IDX, SOC_EXIT_VALUE_OFS), exit_rand, 32'd0);
    add_step(STEP_READ, reg_addr(SOC_CTRL_IDX, SOC_EXIT_VALUE_OFS), 32'd0, exit_rand);
    add_step(STEP_WRITE, reg_addr(SOC_CTRL_IDX, SOC_EXIT_VALID_OFS), 32'd1, 32'd0);
    add_step(STEP_READ, reg_addr(SOC_CTRL_IDX, SOC_EXIT_VALID_OFS), 32'd0, 32'd1);
    for (int p = 0; p < NUM_PAD; p++) begin
      d = next_rand();
      pad_exp[p] = d[15:0];
      add_step(STEP_WRITE, reg_addr(PAD_ATTRIBUTE_IDX, 4'(p)), d, 32'd0);
      add_step(STEP_READ, reg_addr(PAD_ATTRIBUTE_IDX, 4'(p)), 32'd0, {16'b0, d[15:0]});
    end
    // Unmapped peripheral and a pad offset past the last pad
    add_step(STEP_READ, reg_addr(4'd5, 4'd0), 32'd0, ERR_RDATA);
    add_step(STEP_READ, reg_addr(PAD_ATTRIBUTE_IDX, 4'd8), 32'd0, ERR_RDATA);
    add_step(STEP_TIMER_IRQ, 32'd0, 32'd10 + (next_rand() & 32'h7), 32'd0);
    add_step(STEP_TIMER_IRQ, 32'd1, 32'd10 + (next_rand() & 32'h7), 32'd0);
    add_step(STEP_WRITE, reg_addr(POWER_MANAGER_IDX, PM_CPU_GATE_EN_OFS), 32'd1, 32'd0);
    add_step(STEP_SLEEP, 32'd0, 32'd0, 32'd0);
    add_step(STEP_WAKE, 32'd0, 32'd1, 32'd0);
    // gpio 0 is wake bit 4
    add_step(STEP_WRITE, reg_addr(POWER_MANAGER_IDX, PM_WAKE_MASK_OFS), 32'h10, 32'd0);
    add_step(STEP_WAKE, 32'd0, 32'd1, 32'd1);
    add_step(STEP_READ, reg_addr(POWER_MANAGER_IDX, PM_STATUS_OFS), 32'd0, 32'(PM_ACTIVE));
  endtask

  initial begin
    clk                = 1'b0;
    rst_n              = 1'b0;
    slave_req          = '0;
    boot_select        = 1'b1;
    execute_from_flash = 1'b0;
    gpio_intr          = '0;
    ext_intr           = '0;
    core_sleep         = 1'b0;
    timer_2_intr       = 1'b0;
    timer_3_intr       = 1'b0;
    rng_state          = 32'hde54_c158;
    build_table();
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    check("cpu_subsystem_powergate_switch_o", 32'(cpu_sw), 32'd1);
    check("cpu_subsystem_rst_no", 32'(cpu_rst_n), 32'd1);
    check("peripheral_subsystem_powergate_switch_o", 32'(periph_sw), 32'd1);
    check("peripheral_subsystem_rst_no", 32'(periph_rst_n), 32'd1);
    check("memory_subsystem_banks_powergate_switches_o", 32'(bank_sw), 32'(2'b11));
    check("memory_subsystem_rst_no", 32'(bank_rst_n), 32'(2'b11));
    check("exit_valid_o", 32'(exit_valid), 32'd0);
    check("timer_0_intr_o", 32'(timer_0_intr), 32'd0);
    check("timer_1_intr_o", 32'(timer_1_intr), 32'd0);
    check("slave_resp_o.rvalid", 32'(slave_resp.rvalid), 32'd0);
    for (int p = 0; p < NUM_PAD; p++) begin
      check($sformatf("pad_attributes_o[%0d]", p), 32'(pad_attr[p]), 32'd0);
    end

    foreach (steps[i]) begin
      case (steps[i].kind)
        STEP_WRITE: bus_access(1'b1, steps[i].addr, steps[i].data, rd);
        STEP_READ: begin
          bus_access(1'b0, steps[i].addr, 32'd0, rd);
          check($sformatf("rdata at %h", steps[i].addr), rd, steps[i].exp);
        end
        STEP_TIMER_IRQ: run_timer(int'(steps[i].addr), steps[i].data);
        STEP_SLEEP: sleep_cpu();
        STEP_WAKE: wake_cpu(steps[i].data[NUM_GPIO_IRQ-1:0], steps[i].exp[0]);
        default: stop_run("Unknown step kind in the stimulus table");
      endcase
    end

    check("exit_valid_o", 32'(exit_valid), 32'd1);
    check("exit_value_o", exit_value, exit_rand);
    for (int p = 0; p < NUM_PAD; p++) begin
      check($sformatf("pad_attributes_o[%0d]", p), 32'(pad_attr[p]), 32'(pad_exp[p]));
    end
    bank_cycle(0);
    bank_cycle(1);

    $display("Test OK");
    $finish;
  end

endmodule : tb_ao_peripheral_subsystem

`default_nettype wire

// ==== hw/ao_peripheral_subsystem.sv ====
////////////////////
// Always-on block behind one OBI slave port
// Timer 2 and 3 interrupts come from outside and only feed wake-up
////////////////////
`default_nettype none

module ao_peripheral_subsystem (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ao_periph_pkg::obi_req_t                     slave_req_i,
  output ao_periph_pkg::obi_resp_t                    slave_resp_o,
  input  logic                                        boot_select_i,
  input  logic                                        execute_from_flash_i,
  output logic                                        exit_valid_o,
  output logic [31:0]                                 exit_value_o,
  input  logic [ao_periph_pkg::NUM_GPIO_IRQ-1:0]      gpio_intr_i,
  input  logic [ao_periph_pkg::NUM_EXT_IRQ-1:0]       ext_intr_i,
  input  logic                                        core_sleep_i,
  output logic                                        cpu_subsystem_powergate_switch_o,
  output logic                                        peripheral_subsystem_powergate_switch_o,
  output logic [ao_periph_pkg::NUM_BANKS-1:0]         memory_subsystem_banks_powergate_switches_o,
  output logic                                        cpu_subsystem_rst_no,
  output logic                                        peripheral_subsystem_rst_no,
  output logic [ao_periph_pkg::NUM_BANKS-1:0]         memory_subsystem_rst_no,
  output logic                                        timer_0_intr_o,
  output logic                                        timer_1_intr_o,
  input  logic                                        timer_2_intr_i,
  input  logic                                        timer_3_intr_i,
  output logic [ao_periph_pkg::NUM_PAD-1:0][15:0]     pad_attributes_o
);

  import ao_periph_pkg::*;

  reg_req_t                  periph_req;
  reg_rsp_t                  periph_rsp;
  reg_req_t [NUM_PERIPH-1:0] slv_req;
  reg_rsp_t [NUM_PERIPH-1:0] slv_rsp;
  logic [NUM_WAKE_SRC-1:0]   wake_irq;

  assign wake_irq = {ext_intr_i, gpio_intr_i, timer_3_intr_i, timer_2_intr_i,
                     timer_1_intr_o, timer_0_intr_o};

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i (slave_req_i),
    .obi_resp_o(slave_resp_o),
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_demux reg_demux_i (
    .in_req_i (periph_req),
    .in_rsp_o (periph_rsp),
    .out_req_o(slv_req),
    .out_rsp_i(slv_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[SOC_CTRL_IDX]),
    .reg_rsp_o(slv_rsp[SOC_CTRL_IDX]),
    .boot_select_i,
    .execute_from_flash_i,
    .exit_valid_o,
    .exit_value_o
  );

  ao_timer ao_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[TIMER_IDX]),
    .reg_rsp_o(slv_rsp[TIMER_IDX]),
    .timer_0_intr_o,
    .timer_1_intr_o
  );

  power_manager power_manager_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[POWER_MANAGER_IDX]),
    .reg_rsp_o (slv_rsp[POWER_MANAGER_IDX]),
    .wake_irq_i(wake_irq),
    .core_sleep_i,
    .cpu_subsystem_powergate_switch_o,
    .peripheral_subsystem_powergate_switch_o,
    .cpu_subsystem_rst_no,
    .peripheral_subsystem_rst_no,
    .memory_subsystem_banks_powergate_switches_o,
    .memory_subsystem_rst_no
  );

  pad_attribute pad_attribute_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i(slv_req[PAD_ATTRIBUTE_IDX]),
    .reg_rsp_o(slv_rsp[PAD_ATTRIBUTE_IDX]),
    .pad_attributes_o
  );

endmodule : ao_peripheral_subsystem

`default_nettype wire

// ==== hw/pad_attribute.sv ====
////////////////////
// 16-bit attribute per pad, offsets from NUM_PAD up give an error
////////////////////
`default_nettype none

module pad_attribute (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  ao_periph_pkg::reg_req_t                     reg_req_i,
  output ao_periph_pkg::reg_rsp_t                     reg_rsp_o,
  output logic [ao_periph_pkg::NUM_PAD-1:0][15:0]     pad_attributes_o
);

  import ao_periph_pkg::*;

  logic                       hit;
  logic [$clog2(NUM_PAD)-1:0] sel;
  logic [NUM_PAD-1:0][15:0]   pad_q;

  assign hit = 32'(reg_req_i.addr[5:2]) < NUM_PAD;
  assign sel = reg_req_i.addr[2+:$clog2(NUM_PAD)];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pad_q <= '0;
    end else if (reg_req_i.valid && reg_req_i.write && hit) begin
      // Only the low two lanes land in the register
      pad_q[sel] <= 16'(strb_merge(32'(pad_q[sel]), reg_req_i.wdata, reg_req_i.wstrb));
    end
  end

  assign reg_rsp_o.rdata = hit ? 32'(pad_q[sel]) : '0;
  assign reg_rsp_o.error = !hit;

  assign pad_attributes_o = pad_q;

endmodule : pad_attribute

`default_nettype wire

// ==== hw/power_manager.sv ====
////////////////////
// CPU domain sleeps on core_sleep_i when gating is on, wakes on masked irqs
// Peripheral and bank domains follow their software bits
////////////////////
`default_nettype none

module power_manager (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  ao_periph_pkg::reg_req_t                   reg_req_i,
  output ao_periph_pkg::reg_rsp_t                   reg_rsp_o,
  input  logic [ao_periph_pkg::NUM_WAKE_SRC-1:0]    wake_irq_i,
  input  logic                                      core_sleep_i,
  output logic                                      cpu_subsystem_powergate_switch_o,
  output logic                                      peripheral_subsystem_powergate_switch_o,
  output logic                                      cpu_subsystem_rst_no,
  output logic                                      peripheral_subsystem_rst_no,
  output logic [ao_periph_pkg::NUM_BANKS-1:0]       memory_subsystem_banks_powergate_switches_o,
  output logic [ao_periph_pkg::NUM_BANKS-1:0]       memory_subsystem_rst_no
);

  import ao_periph_pkg::*;

  pm_state_e               state_q;
  pm_state_e               state_d;
  logic                    wr;
  logic [3:0]              ofs;
  logic                    cpu_gate_en_q;
  logic [NUM_WAKE_SRC-1:0] wake_mask_q;
  // Bit 0 is the peripheral domain, the banks sit above it
  logic [NUM_BANKS:0]      dom_on_q;
  logic [NUM_BANKS:0]      dom_dly_q;
  logic [NUM_BANKS:0]      dom_sw;
  logic [NUM_BANKS:0]      dom_rst_n;

  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign ofs = reg_req_i.addr[5:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q       <= PM_ACTIVE;
      cpu_gate_en_q <= 1'b0;
      wake_mask_q   <= '0;
      dom_on_q      <= '1;
      dom_dly_q     <= '1;
    end else begin
      state_q   <= state_d;
      dom_dly_q <= dom_on_q;
      if (wr) begin
        case (ofs)
          PM_CPU_GATE_EN_OFS: if (reg_req_i.wstrb[0]) cpu_gate_en_q <= reg_req_i.wdata[0];
          PM_WAKE_MASK_OFS: begin
            wake_mask_q <= NUM_WAKE_SRC'(strb_merge(32'(wake_mask_q), reg_req_i.wdata,
                                                    reg_req_i.wstrb));
          end
          PM_PERIPH_ON_OFS: if (reg_req_i.wstrb[0]) dom_on_q[0] <= reg_req_i.wdata[0];
          PM_BANK_ON_OFS: begin
            if (reg_req_i.wstrb[0]) begin
              dom_on_q[NUM_BANKS:1] <= reg_req_i.wdata[NUM_BANKS-1:0];
            end
          end
          default: ;
        endcase
      end
    end
  end

  // Reset before switch-off, switch-on before reset release
  always_comb begin
    state_d = state_q;
    case (state_q)
      PM_ACTIVE:   if (cpu_gate_en_q && core_sleep_i) state_d = PM_RST_ON;
      PM_RST_ON:   state_d = PM_OFF;
      PM_OFF:      if (|(wake_irq_i & wake_mask_q)) state_d = PM_POWER_UP;
      PM_POWER_UP: state_d = PM_RST_OFF;
      PM_RST_OFF:  state_d = PM_ACTIVE;
      default:     state_d = PM_ACTIVE;
    endcase
  end

  assign cpu_subsystem_powergate_switch_o = (state_q != PM_OFF);
  assign cpu_subsystem_rst_no = (state_q == PM_ACTIVE) || (state_q == PM_RST_OFF);

  // Delayed copy orders switch and reset around each bit change
  assign dom_sw    = dom_on_q | dom_dly_q;
  assign dom_rst_n = dom_on_q & dom_dly_q;

  assign peripheral_subsystem_powergate_switch_o     = dom_sw[0];
  assign peripheral_subsystem_rst_no                 = dom_rst_n[0];
  assign memory_subsystem_banks_powergate_switches_o = dom_sw[NUM_BANKS:1];
  assign memory_subsystem_rst_no                     = dom_rst_n[NUM_BANKS:1];

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      PM_CPU_GATE_EN_OFS: reg_rsp_o.rdata = {31'b0, cpu_gate_en_q};
      PM_WAKE_MASK_OFS:   reg_rsp_o.rdata = 32'(wake_mask_q);
      PM_PERIPH_ON_OFS:   reg_rsp_o.rdata = {31'b0, dom_on_q[0]};
      PM_BANK_ON_OFS:     reg_rsp_o.rdata = 32'(dom_on_q[NUM_BANKS:1]);
      PM_STATUS_OFS:      reg_rsp_o.rdata = 32'(state_q);
      default:            reg_rsp_o.error = 1'b1;
    endcase
  end

  a_off_in_reset : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (cpu_subsystem_powergate_switch_o || !cpu_subsystem_rst_no) &&
    ((~dom_sw & dom_rst_n) == '0)
  );

endmodule : power_manager

`default_nettype wire

// ==== hw/ao_timer.sv ====
////////////////////
// Two free-running 32-bit channels, counters wrap
// Interrupt is a level, cleared by rewriting the count or disabling
////////////////////
`default_nettype none

module ao_timer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    timer_0_intr_o,
  output logic                    timer_1_intr_o
);

  import ao_periph_pkg::*;

  logic             wr;
  logic [3:0]       ofs;
  logic [1:0]       en_q;
  logic [1:0]       intr_q;
  logic [1:0][31:0] cnt_q;
  logic [1:0][31:0] cmp_q;

  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign ofs = reg_req_i.addr[5:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q   <= '0;
      intr_q <= '0;
      cnt_q  <= '0;
      cmp_q  <= '0;
    end else begin
      if (wr && ofs == TMR_CTRL_OFS && reg_req_i.wstrb[0]) begin
        en_q <= reg_req_i.wdata[1:0];
      end
      for (int i = 0; i < 2; i++) begin
        intr_q[i] <= en_q[i] && (cnt_q[i] >= cmp_q[i]);
        // Software write wins over the increment
        if (wr && ofs == TMR_CNT0_OFS + 4'(i)) begin
          cnt_q[i] <= strb_merge(cnt_q[i], reg_req_i.wdata, reg_req_i.wstrb);
        end else if (en_q[i]) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
        if (wr && ofs == TMR_CMP0_OFS + 4'(i)) begin
          cmp_q[i] <= strb_merge(cmp_q[i], reg_req_i.wdata, reg_req_i.wstrb);
        end
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      TMR_CTRL_OFS: reg_rsp_o.rdata = {30'b0, en_q};
      TMR_CMP0_OFS: reg_rsp_o.rdata = cmp_q[0];
      TMR_CMP1_OFS: reg_rsp_o.rdata = cmp_q[1];
      TMR_CNT0_OFS: reg_rsp_o.rdata = cnt_q[0];
      TMR_CNT1_OFS: reg_rsp_o.rdata = cnt_q[1];
      default:      reg_rsp_o.error = 1'b1;
    endcase
  end

  assign timer_0_intr_o = intr_q[0];
  assign timer_1_intr_o = intr_q[1];

endmodule : ao_timer

`default_nettype wire

// ==== hw/soc_ctrl.sv ====
////////////////////
// Exit registers honour byte strobes, boot inputs are read only
////////////////////
`default_nettype none

module soc_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  input  logic                    execute_from_flash_i,
  output logic                    exit_valid_o,
  output logic [31:0]             exit_value_o
);

  import ao_periph_pkg::*;

  logic        wr;
  logic [3:0]  ofs;
  logic        exit_valid_q;
  logic [31:0] exit_value_q;

  assign wr  = reg_req_i.valid && reg_req_i.write;
  assign ofs = reg_req_i.addr[5:2];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr) begin
      if (ofs == SOC_EXIT_VALID_OFS && reg_req_i.wstrb[0]) begin
        exit_valid_q <= reg_req_i.wdata[0];
      end
      if (ofs == SOC_EXIT_VALUE_OFS) begin
        exit_value_q <= strb_merge(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    reg_rsp_o.error = 1'b0;
    case (ofs)
      SOC_EXIT_VALID_OFS: reg_rsp_o.rdata = {31'b0, exit_valid_q};
      SOC_EXIT_VALUE_OFS: reg_rsp_o.rdata = exit_value_q;
      SOC_BOOT_SEL_OFS:   reg_rsp_o.rdata = {31'b0, boot_select_i};
      SOC_FLASH_OFS:      reg_rsp_o.rdata = {31'b0, execute_from_flash_i};
      default:            reg_rsp_o.error = 1'b1;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule : soc_ctrl

`default_nettype wire

// ==== hw/reg_demux.sv ====
////////////////////
// Routes by address bits 15:12, unmapped indices get an error
////////////////////
`default_nettype none

module reg_demux (
  input  ao_periph_pkg::reg_req_t                                in_req_i,
  output ao_periph_pkg::reg_rsp_t                                in_rsp_o,
  output ao_periph_pkg::reg_req_t [ao_periph_pkg::NUM_PERIPH-1:0] out_req_o,
  input  ao_periph_pkg::reg_rsp_t [ao_periph_pkg::NUM_PERIPH-1:0] out_rsp_i
);

  import ao_periph_pkg::*;

  periph_idx_e           sel;
  logic                  mapped;
  logic [1:0]            port;
  logic [NUM_PERIPH-1:0] valid_vec;

  assign sel  = periph_idx_e'(in_req_i.addr[15:12]);
  assign port = sel[1:0];

  always_comb begin
    case (sel)
      SOC_CTRL_IDX, TIMER_IDX, POWER_MANAGER_IDX, PAD_ATTRIBUTE_IDX: mapped = 1'b1;
      default: mapped = 1'b0;
    endcase
  end

  always_comb begin
    for (int unsigned i = 0; i < NUM_PERIPH; i++) begin
      valid_vec[i]       = in_req_i.valid && mapped && (port == 2'(i));
      out_req_o[i]       = in_req_i;
      out_req_o[i].valid = valid_vec[i];
    end
  end

  always_comb begin
    in_rsp_o.rdata = ERR_RDATA;
    in_rsp_o.error = 1'b1;
    if (mapped) begin
      in_rsp_o = out_rsp_i[port];
    end
  end

  // Decode must never select two peripherals
  always_comb begin
    a_one_port_valid : assert ($onehot0(valid_vec));
  end

endmodule : reg_demux

`default_nettype wire

// ==== hw/obi_to_reg.sv ====
////////////////////
// Grants every request at once, no back-pressure
// Read data comes back with rvalid one cycle after the grant
////////////////////
`default_nettype none

module obi_to_reg (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  ao_periph_pkg::obi_req_t  obi_req_i,
  output ao_periph_pkg::obi_resp_t obi_resp_o,
  output ao_periph_pkg::reg_req_t  reg_req_o,
  input  ao_periph_pkg::reg_rsp_t  reg_rsp_i
);

  import ao_periph_pkg::*;

  logic        rvalid_q;
  logic [31:0] rdata_q;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;
  assign reg_req_o.wstrb = obi_req_i.be;

  assign obi_resp_o.gnt    = obi_req_i.req;
  assign obi_resp_o.rvalid = rvalid_q;
  assign obi_resp_o.rdata  = rdata_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= reg_rsp_i.error ? ERR_RDATA : reg_rsp_i.rdata;
    end
  end

  a_rvalid_after_gnt : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) obi_resp_o.rvalid |-> $past(obi_resp_o.gnt)
  );

endmodule : obi_to_reg

`default_nettype wire

// ==== hw/ao_periph_pkg.sv ====
////////////////////
// Shared bus types, address map and sizes of the always-on block
// Register word index is taken from address bits 5:2
////////////////////
`default_nettype none

package ao_periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        error;
  } reg_rsp_t;

  // Peripheral index in address bits 15:12
  typedef enum logic [3:0] {
    SOC_CTRL_IDX      = 4'd0,
    TIMER_IDX         = 4'd1,
    POWER_MANAGER_IDX = 4'd2,
    PAD_ATTRIBUTE_IDX = 4'd3
  } periph_idx_e;

  localparam int unsigned NUM_PERIPH = 4;
  localparam logic [31:0] ERR_RDATA = 32'hbadc_0ffe;

  localparam logic [3:0] SOC_EXIT_VALID_OFS = 4'd0;
  localparam logic [3:0] SOC_EXIT_VALUE_OFS = 4'd1;
  localparam logic [3:0] SOC_BOOT_SEL_OFS   = 4'd2;
  localparam logic [3:0] SOC_FLASH_OFS      = 4'd3;

  localparam logic [3:0] TMR_CTRL_OFS = 4'd0;
  localparam logic [3:0] TMR_CMP0_OFS = 4'd1;
  localparam logic [3:0] TMR_CMP1_OFS = 4'd2;
  localparam logic [3:0] TMR_CNT0_OFS = 4'd3;
  localparam logic [3:0] TMR_CNT1_OFS = 4'd4;

  localparam logic [3:0] PM_CPU_GATE_EN_OFS = 4'd0;
  localparam logic [3:0] PM_WAKE_MASK_OFS   = 4'd1;
  localparam logic [3:0] PM_PERIPH_ON_OFS   = 4'd2;
  localparam logic [3:0] PM_BANK_ON_OFS     = 4'd3;
  localparam logic [3:0] PM_STATUS_OFS      = 4'd4;

  localparam int unsigned NUM_PAD      = 8;
  localparam int unsigned NUM_BANKS    = 2;
  localparam int unsigned NUM_GPIO_IRQ = 8;
  localparam int unsigned NUM_EXT_IRQ  = 4;
  // timer0, timer1, timer2, timer3, gpio, ext from bit 0 up
  localparam int unsigned NUM_WAKE_SRC = 16;

  typedef enum logic [2:0] {
    PM_ACTIVE,
    PM_RST_ON,
    PM_OFF,
    PM_POWER_UP,
    PM_RST_OFF
  } pm_state_e;

  // Byte-lane merge of a register write
  function automatic logic [31:0] strb_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b+:8] = new_val[8*b+:8];
      end
    end
    return res;
  endfunction

endpackage : ao_periph_pkg

`default_nettype wire
